// File: build.f
+incdir+.
kbd_pkg.sv
kbd_event_if.sv
ps2_rx.sv
scan_decoder.sv
kbd_regs.sv
event_fifo.sv
kbd_top.sv
tb_kbd.sv

// File: event_fifo.sv
// Key event queue
// First-word-fall-through buffer filled under credit by the decoder,
// each host pop frees one entry and returns one credit
`include "kbd_cfg.svh"

module event_fifo (
    input  logic                clk,
    input  logic                rst,
    kbd_event_if.dst            ev,
    output logic                ev_valid,   // Head entry present
    output kbd_pkg::scan_code_t ev_code,
    output logic                ev_ext,
    output logic                ev_brk,
    input  logic                ev_pop,     // Host takes the head
    output kbd_pkg::level_t     level
);
    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    kbd_pkg::scan_code_t code_mem [DEPTH];
    logic                ext_mem  [DEPTH];
    logic                brk_mem  [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;             // Wraps at the power-of-two depth
    logic [PTR_W-1:0]    rd_ptr;
    logic                pop;

    // --------------------
    // Head and credit return
    // --------------------
    assign ev_valid  = (level != '0);
    assign pop       = ev_pop && ev_valid;   // Pop on an empty queue does nothing
    assign ev.credit = pop;
    assign ev_code   = code_mem[rd_ptr];
    assign ev_ext    = ext_mem[rd_ptr];
    assign ev_brk    = brk_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (ev.valid) begin
            code_mem[wr_ptr] <= ev.code;
            ext_mem[wr_ptr]  <= ev.ext;
            brk_mem[wr_ptr]  <= ev.brk;
        end
    end

    // --------------------
    // Pointers and level
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (ev.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({ev.valid, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        ev.valid |-> level != kbd_pkg::level_t'(DEPTH))
        else $error("event_fifo write while full");
    assert property (@(posedge clk) disable iff (rst)
        (ev_pop && !ev_valid) |=> level == kbd_pkg::level_t'($past(ev.valid)))
        else $error("event_fifo level moved on a pop while empty");

endmodule

// File: kbd_cfg.svh
// PS/2 keyboard front end configuration
// Queue depth, receiver idle timeout and counter width
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// --------------------
// Event queue
// --------------------

// Entries in the event queue, also the decoder's credits after reset
// Any power of two from 2 up
`define KBD_FIFO_DEPTH 4

// --------------------
// Receiver
// --------------------

// System clocks with no PS/2 falling edge before a partial frame is dropped
`define KBD_IDLE_CYCLES 2000

// --------------------
// Register block
// --------------------

`define KBD_CNT_W 8      // Width of the error and drop counters

`endif

// File: kbd_event_if.sv
// Key event channel from the scan-code decoder into the event queue
// Events go forward and credits come back one per host pop

interface kbd_event_if;

    // --------------------
    // Forward path
    // --------------------
    logic                valid;   // One cycle per event, costs one credit
    kbd_pkg::scan_code_t code;    // Key code with prefixes stripped
    logic                ext;     // Key came after E0
    logic                brk;     // Key release, came after F0

    // --------------------
    // Return path
    // --------------------
    logic                credit;  // One cycle per freed queue slot

    // Decoder side
    modport src (
        output valid,
        output code,
        output ext,
        output brk,
        input  credit
    );

    // Queue side
    modport dst (
        input  valid,
        input  code,
        input  ext,
        input  brk,
        output credit
    );

endinterface

// File: kbd_pkg.sv
// Shared types for the PS/2 keyboard front end
// Byte, counter and level widths, FSM states and the register map
`include "kbd_cfg.svh"

package kbd_pkg;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [7:0]                       scan_code_t;  // One PS/2 byte or key code
    typedef logic [`KBD_CNT_W-1:0]            cnt_t;        // Saturating event counters
    typedef logic [$clog2(`KBD_FIFO_DEPTH):0] level_t;      // Holds 0 up to the full depth
    typedef logic [1:0]                       reg_addr_t;   // Register port address

    // --------------------
    // State machines
    // --------------------

    // Receiver frame position
    typedef enum logic [1:0] {
        rx_idle,    // Waiting for a start bit
        rx_data,    // Eight data bits, LSB first
        rx_parity,  // Odd parity bit
        rx_stop     // Stop bit must be high
    } rx_state_t;

    // Prefix bytes seen so far for the current key
    typedef enum logic [1:0] {
        dec_base,     // No prefix pending
        dec_ext,      // After E0
        dec_brk,      // After F0
        dec_ext_brk   // After E0 F0
    } dec_state_t;

    // --------------------
    // Register map
    // --------------------
    localparam reg_addr_t REG_CTRL   = 2'd0;  // bit0 enable, bit1 report_break
    localparam reg_addr_t REG_STATUS = 2'd1;  // Queue level
    localparam reg_addr_t REG_ERR    = 2'd2;  // Bad frames
    localparam reg_addr_t REG_DROP   = 2'd3;  // Events lost for lack of credit

endpackage

// File: kbd_regs.sv
// Keyboard register block
// Control bits for the decoder, saturating frame error and drop counters
// and a combinational read port

module kbd_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                reg_wr,
    input  kbd_pkg::reg_addr_t  reg_addr,
    input  kbd_pkg::scan_code_t reg_wdata,
    output kbd_pkg::scan_code_t reg_rdata,
    input  logic                frame_err,     // From the receiver
    input  logic                drop,          // From the decoder
    input  kbd_pkg::level_t     level,         // Queue fill level
    output logic                enable,
    output logic                report_break
);
    kbd_pkg::cnt_t err_cnt;
    kbd_pkg::cnt_t drop_cnt;
    logic          clr_err;
    logic          clr_drop;

    // Counter step, a clear beats an increment and the top value holds
    function automatic kbd_pkg::cnt_t sat_next(
        input kbd_pkg::cnt_t cnt,
        input logic          clr,
        input logic          inc
    );
        kbd_pkg::cnt_t nxt;
        nxt = cnt;
        if (clr)
            nxt = '0;
        else if (inc && (cnt != '1))
            nxt = cnt + 1'b1;
        return nxt;
    endfunction

    // Any write to a counter address clears it
    assign clr_err  = reg_wr && (reg_addr == kbd_pkg::REG_ERR);
    assign clr_drop = reg_wr && (reg_addr == kbd_pkg::REG_DROP);

    // --------------------
    // Register updates
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            enable       <= 1'b1;
            report_break <= 1'b1;
            err_cnt      <= '0;
            drop_cnt     <= '0;
        end else begin
            if (reg_wr && (reg_addr == kbd_pkg::REG_CTRL)) begin
                enable       <= reg_wdata[0];
                report_break <= reg_wdata[1];
            end
            err_cnt  <= sat_next(err_cnt, clr_err, frame_err);
            drop_cnt <= sat_next(drop_cnt, clr_drop, drop);
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            kbd_pkg::REG_CTRL:   reg_rdata = {6'b0, report_break, enable};
            kbd_pkg::REG_STATUS: reg_rdata = kbd_pkg::scan_code_t'(level);
            kbd_pkg::REG_ERR:    reg_rdata = kbd_pkg::scan_code_t'(err_cnt);
            kbd_pkg::REG_DROP:   reg_rdata = kbd_pkg::scan_code_t'(drop_cnt);
            default:             ;
        endcase
    end

endmodule

// File: kbd_top.sv
// PS/2 keyboard front end
// Receiver, scan-code decoder, event queue and register block

module kbd_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,     // Asynchronous
    input  logic                ps2_data,    // Asynchronous
    output logic                ev_valid,
    output kbd_pkg::scan_code_t ev_code,
    output logic                ev_ext,
    output logic                ev_brk,
    input  logic                ev_pop,
    input  logic                reg_wr,
    input  kbd_pkg::reg_addr_t  reg_addr,
    input  kbd_pkg::scan_code_t reg_wdata,
    output kbd_pkg::scan_code_t reg_rdata
);
    logic                byte_valid;
    kbd_pkg::scan_code_t rx_byte;
    logic                frame_err;
    logic                drop;
    logic                enable;
    logic                report_break;
    kbd_pkg::level_t     level;

    kbd_event_if ev_if ();   // Decoder to queue

    ps2_rx u_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .frame_err  (frame_err)
    );

    scan_decoder u_dec (
        .clk          (clk),
        .rst          (rst),
        .byte_valid   (byte_valid),
        .rx_byte      (rx_byte),
        .enable       (enable),
        .report_break (report_break),
        .ev           (ev_if.src),
        .drop         (drop)
    );

    event_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .ev       (ev_if.dst),
        .ev_valid (ev_valid),
        .ev_code  (ev_code),
        .ev_ext   (ev_ext),
        .ev_brk   (ev_brk),
        .ev_pop   (ev_pop),
        .level    (level)
    );

    kbd_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .frame_err    (frame_err),
        .drop         (drop),
        .level        (level),
        .enable       (enable),
        .report_break (report_break)
    );

endmodule

// File: ps2_rx.sv
// PS/2 frame receiver
// Synchronizes the keyboard lines, finds falling clock edges and assembles
// 11-bit frames with odd parity and stop checks plus an idle abort
`include "kbd_cfg.svh"

module ps2_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                ps2_clk,     // Asynchronous keyboard clock
    input  logic                ps2_data,    // Asynchronous keyboard data
    output logic                byte_valid,  // Good frame, one cycle
    output kbd_pkg::scan_code_t rx_byte,     // Data byte of the last frame
    output logic                frame_err    // Bad parity or stop bit, one cycle
);
    localparam int IDLE_W = $clog2(`KBD_IDLE_CYCLES + 1);

    logic                clk_s1;
    logic                clk_s2;
    logic                clk_d;      // Previous synchronized clock
    logic                fall;       // Registered falling edge
    logic                data_s1;
    logic                data_s2;
    kbd_pkg::rx_state_t  state;
    logic [3:0]          bit_cnt;    // Index of the next frame bit
    kbd_pkg::scan_code_t shreg;
    logic                par_bit;
    logic [IDLE_W-1:0]   idle_cnt;
    logic                timeout;

    // --------------------
    // Synchronizer and edge
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_s1 <= 1'b1;              // Idle line is high
            clk_s2 <= 1'b1;
            clk_d  <= 1'b1;
            fall   <= 1'b0;
        end else begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            clk_d  <= clk_s2;
            fall   <= clk_d & ~clk_s2;   // Seen 3 clocks after the pin
        end
    end

    always_ff @(posedge clk) begin
        data_s1 <= ps2_data;
        data_s2 <= data_s1;              // Stable for half a PS/2 period
    end

    // --------------------
    // Frame assembly
    // --------------------
    assign timeout = (idle_cnt == IDLE_W'(`KBD_IDLE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= kbd_pkg::rx_idle;
            bit_cnt    <= 4'd0;
            idle_cnt   <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            // Quiet time inside a frame
            idle_cnt <= (state == kbd_pkg::rx_idle || fall) ? '0 : idle_cnt + 1'b1;
            if (fall) begin
                case (state)
                    kbd_pkg::rx_idle: begin
                        if (!data_s2) begin           // Start bit is low
                            state   <= kbd_pkg::rx_data;
                            bit_cnt <= 4'd1;
                        end
                    end
                    kbd_pkg::rx_data: begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd8)
                            state <= kbd_pkg::rx_parity;  // Last data bit
                    end
                    kbd_pkg::rx_parity: begin
                        bit_cnt <= 4'd10;
                        state   <= kbd_pkg::rx_stop;
                    end
                    default: begin                    // Stop bit
                        bit_cnt <= 4'd0;
                        state   <= kbd_pkg::rx_idle;
                        if (data_s2 && (^shreg ^ par_bit))
                            byte_valid <= 1'b1;
                        else
                            frame_err  <= 1'b1;
                    end
                endcase
            end else if (timeout) begin
                // Partial frame abandoned, not an error
                state   <= kbd_pkg::rx_idle;
                bit_cnt <= 4'd0;
            end
        end
    end

    // Payload shift, LSB arrives first
    always_ff @(posedge clk) begin
        if (fall && state == kbd_pkg::rx_data)
            shreg <= {data_s2, shreg[7:1]};
        if (fall && state == kbd_pkg::rx_parity)
            par_bit <= data_s2;
    end

    assign rx_byte = shreg;  // Holds until the next frame shifts in

    assert property (@(posedge clk) disable iff (rst) !(byte_valid && frame_err))
        else $error("ps2_rx good and bad frame flagged together");
    assert property (@(posedge clk) disable iff (rst) bit_cnt <= 4'd10)
        else $error("ps2_rx bit counter beyond the stop bit");

endmodule

// File: scan_decoder.sv
// Scan-code decoder
// Folds E0 and F0 prefixes into one key event and sends it to the queue
// under credit flow control, with a drop pulse when no credit is left
`include "kbd_cfg.svh"

module scan_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                byte_valid,
    input  kbd_pkg::scan_code_t rx_byte,
    input  logic                enable,
    input  logic                report_break,
    kbd_event_if.src            ev,
    output logic                drop          // Event lost, one cycle
);
    localparam kbd_pkg::scan_code_t CODE_EXT   = 8'hE0;
    localparam kbd_pkg::scan_code_t CODE_BRK   = 8'hF0;
    localparam kbd_pkg::level_t     CREDIT_MAX = kbd_pkg::level_t'(`KBD_FIFO_DEPTH);

    kbd_pkg::dec_state_t state;
    kbd_pkg::dec_state_t pre_state;   // State after a prefix byte
    kbd_pkg::level_t     credits;     // Free queue slots
    logic                cur_ext;
    logic                cur_brk;
    logic                is_prefix;
    logic                new_ev;      // Ordinary byte turning into an event
    logic                take;        // Event sent, costs one credit

    // --------------------
    // Prefix tracking
    // --------------------
    assign cur_ext   = (state == kbd_pkg::dec_ext) || (state == kbd_pkg::dec_ext_brk);
    assign cur_brk   = (state == kbd_pkg::dec_brk) || (state == kbd_pkg::dec_ext_brk);
    assign is_prefix = (rx_byte == CODE_EXT) || (rx_byte == CODE_BRK);

    always_comb begin
        case ({cur_ext | (rx_byte == CODE_EXT), cur_brk | (rx_byte == CODE_BRK)})
            2'b10:   pre_state = kbd_pkg::dec_ext;
            2'b01:   pre_state = kbd_pkg::dec_brk;
            2'b11:   pre_state = kbd_pkg::dec_ext_brk;
            default: pre_state = kbd_pkg::dec_base;
        endcase
    end

    // Silent releases are neither sent nor counted
    assign new_ev = byte_valid && enable && !is_prefix && !(cur_brk && !report_break);
    assign take   = new_ev && (credits != '0);

    // --------------------
    // State, outputs, credits
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= kbd_pkg::dec_base;
            ev.valid <= 1'b0;
            drop     <= 1'b0;
            credits  <= CREDIT_MAX;          // Queue starts empty
        end else begin
            ev.valid <= take;
            drop     <= new_ev && (credits == '0);
            if (!enable)
                state <= kbd_pkg::dec_base;  // Bytes ignored while disabled
            else if (byte_valid)
                state <= is_prefix ? pre_state : kbd_pkg::dec_base;
            case ({take, ev.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;                   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (new_ev) begin
            ev.code <= rx_byte;
            ev.ext  <= cur_ext;
            ev.brk  <= cur_brk;
        end
    end

    assert property (@(posedge clk) disable iff (rst) ev.valid |-> $past(credits) != '0)
        else $error("scan_decoder sent an event without credit");
    assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_MAX)
        else $error("scan_decoder holds more credits than queue entries");

endmodule

// File: tb_kbd.sv
// Testbench for the PS/2 keyboard front end
// Keyboard and host models drive kbd_top, and a reference queue of key
// events with expected counters checks what comes out
`include "kbd_cfg.svh"

module tb_kbd;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_BIT = 20;                        // PS/2 half-period in clocks
    localparam int N_FRAMES = 100 + `KBD_FIFO_DEPTH;     // Upper bound on frames sent
    localparam int LIMIT    = N_FRAMES * 11 * 40 * 2 + 2 * `KBD_IDLE_CYCLES;

    logic                clk = 1'b0;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_data;
    logic                ev_valid;
    kbd_pkg::scan_code_t ev_code;
    logic                ev_ext;
    logic                ev_brk;
    logic                ev_pop;
    logic                reg_wr;
    kbd_pkg::reg_addr_t  reg_addr;
    kbd_pkg::scan_code_t reg_wdata;
    kbd_pkg::scan_code_t reg_rdata;

    // Reference model state
    logic [9:0]  exp_q[$];              // {brk, ext, code} in arrival order
    int          exp_err  = 0;
    int          exp_drop = 0;
    logic        m_ext    = 1'b0;       // Prefixes pending in the model
    logic        m_brk    = 1'b0;
    logic        m_enable = 1'b1;
    logic        m_report_break = 1'b1;
    logic        host_en  = 1'b1;       // Host pops when set
    logic [31:0] stim_rng = 32'hd36b;
    logic [31:0] host_rng = 32'hd36b;
    int          check_errs = 0;
    int          other_errs = 0;
    int          cycles     = 0;

    kbd_top dut (.*);

    always #4 clk = ~clk;               // 8 ns period

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            check_errs++;
            $display("CHECK FAILED time %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;                             // Inputs move just after the edge
    endtask

    task automatic write_reg(input kbd_pkg::reg_addr_t a, input kbd_pkg::scan_code_t d);
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        tick();
        reg_wr    = 1'b0;
    endtask

    // Combinational read data is sampled mid-cycle
    task automatic check_reg(input string name, input kbd_pkg::reg_addr_t a,
                             input logic [31:0] exp);
        reg_addr = a;
        @(negedge clk);
        check(name, exp, reg_rdata);
        tick();
    endtask

    // Random ordinary key code that is never a prefix byte
    task automatic next_code(output kbd_pkg::scan_code_t c);
        stim_rng = xorshift(stim_rng);
        c = stim_rng[7:0];
        if (c == 8'hE0 || c == 8'hF0)
            c = c ^ 8'h01;
    endtask

    // --------------------
    // Keyboard model
    // --------------------

    // Frame is start, 8 data LSB first, odd parity, stop; nbits < 11 cuts it short
    task automatic send_frame(input kbd_pkg::scan_code_t d, input logic bad_par,
                              input logic bad_stop, input int nbits);
        logic [10:0] frame;
        frame = {~bad_stop, (~^d) ^ bad_par, d, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            ps2_data = frame[i];
            repeat (HALF_BIT) tick();
            ps2_clk = 1'b0;             // Keyboard clocks the bit out
            repeat (HALF_BIT) tick();
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;                // Release the line
        repeat (40) tick();
    endtask

    // Reference model decode rules applied before the byte is sent
    task automatic model_byte(input kbd_pkg::scan_code_t b);
        if (!m_enable) begin
            m_ext = 1'b0;
            m_brk = 1'b0;
        end else if (b == 8'hE0) begin
            m_ext = 1'b1;
        end else if (b == 8'hF0) begin
            m_brk = 1'b1;
        end else begin
            if (!(m_brk && !m_report_break)) begin      // Silent release otherwise
                if (exp_q.size() < `KBD_FIFO_DEPTH)
                    exp_q.push_back({m_brk, m_ext, b});
                else
                    exp_drop++;                         // No credit left
            end
            m_ext = 1'b0;
            m_brk = 1'b0;
        end
    endtask

    task automatic send_byte(input kbd_pkg::scan_code_t b);
        model_byte(b);
        send_frame(b, 1'b0, 1'b0, 11);
    endtask

    // Kind 0 E0 code, 1 F0 code, 2 E0 F0 code
    task automatic send_prefixed(input int kind);
        kbd_pkg::scan_code_t c;
        next_code(c);
        if (kind != 1)
            send_byte(8'hE0);
        if (kind != 0)
            send_byte(8'hF0);
        send_byte(c);
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            tick();
        repeat (20) tick();
    endtask

    // --------------------
    // Host model
    // --------------------
    always @(posedge clk) begin : host_model
        logic [9:0] head;
        #1;
        ev_pop = 1'b0;
        if (!rst && host_en && ev_valid) begin
            host_rng = xorshift(host_rng);
            if (host_rng[1:0] != 2'b00) begin               // Pop 3 times in 4
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("Event %0h came out at time %0t with none expected",
                             ev_code, $time);
                end else begin
                    head = exp_q.pop_front();
                    check("ev_code", head[7:0], ev_code);
                    check("ev_ext", head[8], ev_ext);
                    check("ev_brk", head[9], ev_brk);
                end
                ev_pop = 1'b1;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Run did not finish within %0d cycles", LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        kbd_pkg::scan_code_t c;
        rst       = 1'b1;
        ps2_clk   = 1'b1;               // Idle PS/2 lines are high
        ps2_data  = 1'b1;
        ev_pop    = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = kbd_pkg::REG_CTRL;
        reg_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();
        check_reg("CTRL", kbd_pkg::REG_CTRL, 3);
        check_reg("STATUS", kbd_pkg::REG_STATUS, 0);

        // Plain make codes in order
        for (int i = 0; i < 20; i++) begin
            next_code(c);
            send_byte(c);
        end
        drain();

        // Extended and break prefixes
        for (int i = 0; i < 12; i++) begin
            stim_rng = xorshift(stim_rng);
            send_prefixed(stim_rng % 3);
        end
        drain();

        // Bad parity and bad stop frames
        for (int i = 0; i < 7; i++) begin
            next_code(c);
            send_frame(c, i < 4, i >= 4, 11);
            exp_err++;
        end
        check_reg("ERR", kbd_pkg::REG_ERR, exp_err);
        write_reg(kbd_pkg::REG_ERR, 8'h55);
        exp_err = 0;
        check_reg("ERR", kbd_pkg::REG_ERR, exp_err);
        check_reg("STATUS", kbd_pkg::REG_STATUS, 0);

        // Host stalls, queue fills and the rest is dropped
        write_reg(kbd_pkg::REG_DROP, 8'h00);
        exp_drop = 0;
        host_en  = 1'b0;
        for (int i = 0; i < `KBD_FIFO_DEPTH + 3; i++) begin
            next_code(c);
            send_byte(c);
        end
        check_reg("STATUS", kbd_pkg::REG_STATUS, `KBD_FIFO_DEPTH);
        check_reg("DROP", kbd_pkg::REG_DROP, exp_drop);
        host_en = 1'b1;
        drain();
        check_reg("STATUS", kbd_pkg::REG_STATUS, 0);

        // Break reporting off
        write_reg(kbd_pkg::REG_CTRL, 8'h01);
        m_report_break = 1'b0;
        check_reg("CTRL", kbd_pkg::REG_CTRL, 1);
        for (int i = 0; i < 4; i++)
            send_prefixed(1 + (i % 2));
        next_code(c);
        send_byte(c);                   // Make codes still get through
        drain();
        check_reg("DROP", kbd_pkg::REG_DROP, exp_drop);

        // Decoder disabled, host holds off so a stray event stays queued
        host_en = 1'b0;
        write_reg(kbd_pkg::REG_CTRL, 8'h02);
        m_report_break = 1'b1;
        m_enable       = 1'b0;
        for (int i = 0; i < 5; i++) begin
            next_code(c);
            send_byte(c);
        end
        write_reg(kbd_pkg::REG_CTRL, 8'h03);
        m_enable = 1'b1;
        check_reg("STATUS", kbd_pkg::REG_STATUS, 0);
        host_en = 1'b1;

        // Cut-off frame, quiet gap past the idle timeout, then a full frame
        next_code(c);
        send_frame(c, 1'b0, 1'b0, 5);
        repeat (`KBD_IDLE_CYCLES + 100) tick();
        next_code(c);
        send_byte(c);
        drain();
        check_reg("ERR", kbd_pkg::REG_ERR, exp_err);
        check_reg("DROP", kbd_pkg::REG_DROP, exp_drop);
        check("ev_valid", 0, ev_valid);

        $display("Finished: %0d check mismatches, %0d other errors", check_errs, other_errs);
        if (check_errs == 0 && other_errs == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule
